//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN      = 64;
    localparam int ID_W      = 6;
    localparam int PREG_W    = 7;
    localparam int MDU_STEPS = XLEN;              // One result bit per iteration
    localparam int MDU_CNT_W = $clog2(MDU_STEPS);

    typedef enum logic {
        SIZE_D = 1'b0,  // Full 64-bit operation
        SIZE_W = 1'b1   // 32-bit, result sign-extended from bit 31
    } size_e;

    typedef enum logic [4:0] {
        ADD   = 5'h00,
        SUB   = 5'h01,
        LUI   = 5'h02,
        AUIPC = 5'h03,
        SLL   = 5'h04,
        SRL   = 5'h05,
        SRA   = 5'h06,
        AND   = 5'h07,
        OR    = 5'h08,
        XOR   = 5'h09,
        SLT   = 5'h0a,
        SLTU  = 5'h0b
    } alu_op_e;

    // Top bit set, so these never alias an ALU code
    typedef enum logic [4:0] {
        MUL   = 5'h10,
        MULHU = 5'h11,
        DIVU  = 5'h12,
        REMU  = 5'h13
    } mdu_op_e;

    // One operation word, read by either unit
    typedef union packed {
        alu_op_e alu;
        mdu_op_e mdu;
    } fu_op_u;

    // Routing decision between ALU and multiply/divide unit
    function automatic logic is_mdu_op(input fu_op_u op);
        return op.mdu[4];
    endfunction

endpackage

`default_nettype wire

//--- fu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module fu_alu (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  exec_pkg::fu_op_u          op_i,
    input  exec_pkg::size_e           size_i,
    input  logic [exec_pkg::XLEN-1:0] rs1val_i,
    input  logic [exec_pkg::XLEN-1:0] rs2val_i,
    input  logic [exec_pkg::XLEN-1:0] imm_i,
    output logic [exec_pkg::XLEN-1:0] result_o
);
    import exec_pkg::*;

    logic            is_word;
    logic [5:0]      shamt;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;

    logic            sub_mode;
    logic [XLEN+1:0] add_a;
    logic [XLEN+1:0] add_b;
    logic [XLEN+1:0] add_sum;
    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] add_final;
    logic            slt_res;
    logic            sltu_res;

    logic            shift_l;
    logic            shift_a;
    logic [XLEN-1:0] rs1_rev64;
    logic [31:0]     rs1_rev32;
    logic [XLEN-1:0] sh_in64;
    logic [31:0]     sh_in32;
    logic [XLEN:0]   sh_out65;
    logic [32:0]     sh_out33;
    logic [XLEN-1:0] sh_rev64;
    logic [31:0]     sh_rev32;
    logic [XLEN-1:0] sh_res64;
    logic [31:0]     sh_res32;
    logic [XLEN-1:0] shift_final;

    assign is_word = (size_i == SIZE_W);
    assign shamt   = imm_i[5:0];  // Register shifts arrive with rs2 copied into imm

    // LUI adds the immediate to zero, AUIPC to the pc carried in rs1
    assign opa = (op_i.alu == LUI) ? '0 : rs1val_i;
    assign opb = (op_i.alu inside {LUI, AUIPC}) ? imm_i : rs2val_i;

    // Adder widened by one bit each side, low bit injects the +1 of subtraction
    assign sub_mode  = op_i.alu inside {SUB, SLT, SLTU};
    assign add_a     = {1'b0, opa, 1'b1};
    assign add_b     = {1'b0, opb, 1'b0} ^ {(XLEN+2){sub_mode}};
    assign add_sum   = add_a + add_b;
    assign add_res   = add_sum[XLEN:1];
    assign add_final = is_word ? {{(XLEN-32){add_res[31]}}, add_res[31:0]} : add_res;
    // Mixed signs decide directly, otherwise the difference sign
    assign slt_res   = (opa[XLEN-1] ^ opb[XLEN-1]) ? opa[XLEN-1] : add_res[XLEN-1];
    assign sltu_res  = add_sum[XLEN+1];  // Borrow out of the top

    // Single right shifter, left shifts go through bit reversal
    assign shift_l   = (op_i.alu == SLL);
    assign shift_a   = (op_i.alu == SRA);
    assign rs1_rev64 = {<<{rs1val_i}};
    assign rs1_rev32 = {<<{rs1val_i[31:0]}};
    assign sh_in64   = shift_l ? rs1_rev64 : rs1val_i;
    assign sh_in32   = shift_l ? rs1_rev32 : rs1val_i[31:0];
    assign sh_out65  = $unsigned($signed({shift_a & sh_in64[XLEN-1], sh_in64}) >>> shamt);
    assign sh_out33  = $unsigned($signed({shift_a & sh_in32[31], sh_in32}) >>> shamt[4:0]);
    assign sh_rev64  = {<<{sh_out65[XLEN-1:0]}};
    assign sh_rev32  = {<<{sh_out33[31:0]}};
    assign sh_res64  = shift_l ? sh_rev64 : sh_out65[XLEN-1:0];
    assign sh_res32  = shift_l ? sh_rev32 : sh_out33[31:0];
    assign shift_final = is_word ? {{(XLEN-32){sh_res32[31]}}, sh_res32} : sh_res64;

    always_comb begin
        unique case (op_i.alu)
            ADD, SUB, LUI, AUIPC: result_o = add_final;
            SLL, SRL, SRA:        result_o = shift_final;
            AND:                  result_o = rs1val_i & rs2val_i;
            OR:                   result_o = rs1val_i | rs2val_i;
            XOR:                  result_o = rs1val_i ^ rs2val_i;
            SLT:                  result_o = {{(XLEN-1){1'b0}}, slt_res};
            SLTU:                 result_o = {{(XLEN-1){1'b0}}, sltu_res};
            default:              result_o = '0;  // Multiply/divide codes
        endcase
    end

    // Reversal and sign fill must never combine
    a_shift_mode: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(shift_l && shift_a)
    );

endmodule

`default_nettype wire

//--- mdu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic last_i,
    input  logic parked_i,
    output logic load_o,
    output logic step_o,
    output logic cnt_clr_o,
    output logic cnt_en_o,
    output logic done_o,
    output logic busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (last_i) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Operands captured and counter cleared in the start cycle itself
    assign load_o    = (state_q == IDLE) && start_i;
    assign cnt_clr_o = (state_q == IDLE) && start_i;
    assign step_o    = (state_q == RUN);
    assign cnt_en_o  = (state_q == RUN) && !last_i;  // Counter holds on the final step
    assign done_o    = (state_q == DONE);
    assign busy_o    = (state_q != IDLE) || parked_i;  // Held until writeback drains

    // Issuer must respect busy
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i) start_i |-> !busy_o
    );

endmodule

`default_nettype wire

//--- mdu_cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_cycle_counter (
    input  logic clk,
    input  logic rst_n_i,
    input  logic clr_i,
    input  logic en_i,
    output logic last_o
);
    import exec_pkg::*;

    logic [MDU_CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign last_o = (cnt_q == MDU_CNT_W'(MDU_STEPS - 1));

    // Controller drops the enable before the count can roll over
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n_i) en_i |-> (cnt_q != '1)
    );

endmodule

`default_nettype wire

//--- mdu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_datapath (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        load_i,
    input  logic                        step_i,
    input  exec_pkg::fu_op_u            op_i,
    input  logic [exec_pkg::XLEN-1:0]   rs1val_i,
    input  logic [exec_pkg::XLEN-1:0]   rs2val_i,
    input  logic [exec_pkg::XLEN-1:0]   pc_i,
    input  logic [exec_pkg::ID_W-1:0]   id_i,
    input  logic [exec_pkg::PREG_W-1:0] prd_i,
    output logic [exec_pkg::XLEN-1:0]   result_o,
    output logic [exec_pkg::XLEN-1:0]   pc_o,
    output logic [exec_pkg::ID_W-1:0]   id_o,
    output logic [exec_pkg::PREG_W-1:0] prd_o
);
    import exec_pkg::*;

    // Product for multiply, {remainder, quotient} for divide
    logic [2*XLEN-1:0] acc_q;
    logic [XLEN-1:0]   opb_q;  // Multiplicand or divisor
    fu_op_u            op_q;
    logic [XLEN-1:0]   pc_q;
    logic [ID_W-1:0]   id_q;
    logic [PREG_W-1:0] prd_q;

    logic [XLEN-1:0]   hi;
    logic [XLEN-1:0]   lo;
    logic              is_mul;
    logic [XLEN:0]     mul_sum;
    logic [2*XLEN-1:0] acc_mul;
    logic [XLEN:0]     div_shift;
    logic [XLEN+1:0]   div_diff;
    logic              div_neg;
    logic [2*XLEN-1:0] acc_div;

    assign hi     = acc_q[2*XLEN-1:XLEN];
    assign lo     = acc_q[XLEN-1:0];
    assign is_mul = op_q.mdu inside {MUL, MULHU};

    // Shift-add, add the multiplicand when the low multiplier bit is set
    assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, opb_q} : {(XLEN+1){1'b0}});
    assign acc_mul = {mul_sum, lo[XLEN-1:1]};

    // Restoring divide, one quotient bit enters at the bottom per step
    assign div_shift = {hi, lo[XLEN-1]};
    assign div_diff  = {1'b0, div_shift} - {2'b00, opb_q};
    assign div_neg   = div_diff[XLEN+1];
    assign acc_div   = div_neg ? {div_shift[XLEN-1:0], lo[XLEN-2:0], 1'b0}
                               : {div_diff[XLEN-1:0], lo[XLEN-2:0], 1'b1};
    // Divisor zero never borrows, so quotient is all ones and remainder the dividend

    always_ff @(posedge clk) begin
        if (load_i) begin
            acc_q <= {{XLEN{1'b0}}, rs1val_i};
            opb_q <= rs2val_i;
            op_q  <= op_i;
            pc_q  <= pc_i;
            id_q  <= id_i;
            prd_q <= prd_i;
        end else if (step_i) begin
            acc_q <= is_mul ? acc_mul : acc_div;
        end
    end

    always_comb begin
        unique case (op_q.mdu)
            MUL, DIVU:   result_o = lo;
            MULHU, REMU: result_o = hi;
            default:     result_o = lo;
        endcase
    end

    assign pc_o  = pc_q;
    assign id_o  = id_q;
    assign prd_o = prd_q;

    // A new load must never cut into a running iteration
    a_load_step: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(load_i && step_i)
    );

endmodule

`default_nettype wire

//--- exec_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module exec_writeback (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        alu_valid_i,
    input  logic [exec_pkg::XLEN-1:0]   alu_result_i,
    input  logic [exec_pkg::XLEN-1:0]   alu_pc_i,
    input  logic [exec_pkg::ID_W-1:0]   alu_id_i,
    input  logic [exec_pkg::PREG_W-1:0] alu_prd_i,
    input  logic                        mdu_done_i,
    input  logic [exec_pkg::XLEN-1:0]   mdu_result_i,
    input  logic [exec_pkg::XLEN-1:0]   mdu_pc_i,
    input  logic [exec_pkg::ID_W-1:0]   mdu_id_i,
    input  logic [exec_pkg::PREG_W-1:0] mdu_prd_i,
    output logic                        parked_o,
    output logic                        wb_valid_o,
    output logic [exec_pkg::ID_W-1:0]   wb_id_o,
    output logic [exec_pkg::PREG_W-1:0] wb_prd_o,
    output logic [exec_pkg::XLEN-1:0]   wb_pc_o,
    output logic [exec_pkg::XLEN-1:0]   wb_rdval_o
);
    import exec_pkg::*;

    logic              parked_q;
    logic              collide;
    logic [XLEN-1:0]   park_result_q;
    logic [XLEN-1:0]   park_pc_q;
    logic [ID_W-1:0]   park_id_q;
    logic [PREG_W-1:0] park_prd_q;

    assign collide = alu_valid_i && mdu_done_i;  // ALU wins, MDU waits

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            parked_q   <= 1'b0;
        end else begin
            wb_valid_o <= alu_valid_i || mdu_done_i || parked_q;
            if (collide) begin
                parked_q <= 1'b1;
            end else if (!alu_valid_i) begin
                parked_q <= 1'b0;  // Parked result goes out this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (collide) begin
            park_result_q <= mdu_result_i;
            park_pc_q     <= mdu_pc_i;
            park_id_q     <= mdu_id_i;
            park_prd_q    <= mdu_prd_i;
        end
        if (alu_valid_i) begin
            wb_rdval_o <= alu_result_i;
            wb_pc_o    <= alu_pc_i;
            wb_id_o    <= alu_id_i;
            wb_prd_o   <= alu_prd_i;
        end else if (parked_q) begin
            wb_rdval_o <= park_result_q;
            wb_pc_o    <= park_pc_q;
            wb_id_o    <= park_id_q;
            wb_prd_o   <= park_prd_q;
        end else if (mdu_done_i) begin
            wb_rdval_o <= mdu_result_i;
            wb_pc_o    <= mdu_pc_i;
            wb_id_o    <= mdu_id_i;
            wb_prd_o   <= mdu_prd_i;
        end
    end

    assign parked_o = parked_q;

    // Busy keeps the next MDU op out until the parked slot drains
    a_no_done_parked: assert property (
        @(posedge clk) disable iff (!rst_n_i) mdu_done_i |-> !parked_q
    );

endmodule

`default_nettype wire

//--- exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        issue_valid_i,
    input  exec_pkg::fu_op_u            op_i,
    input  exec_pkg::size_e             size_i,
    input  logic [exec_pkg::XLEN-1:0]   rs1val_i,
    input  logic [exec_pkg::XLEN-1:0]   rs2val_i,
    input  logic [exec_pkg::XLEN-1:0]   imm_i,
    input  logic [exec_pkg::XLEN-1:0]   pc_i,
    input  logic [exec_pkg::ID_W-1:0]   id_i,
    input  logic [exec_pkg::PREG_W-1:0] prd_i,
    output logic                        busy_o,
    output logic                        wb_valid_o,
    output logic [exec_pkg::ID_W-1:0]   wb_id_o,
    output logic [exec_pkg::PREG_W-1:0] wb_prd_o,
    output logic [exec_pkg::XLEN-1:0]   wb_pc_o,
    output logic [exec_pkg::XLEN-1:0]   wb_rdval_o
);
    import exec_pkg::*;

    logic              alu_valid;
    logic              mdu_start;
    logic [XLEN-1:0]   alu_result;

    logic              mdu_load;
    logic              mdu_step;
    logic              cnt_clr;
    logic              cnt_en;
    logic              cnt_last;
    logic              mdu_done;
    logic              parked;
    logic [XLEN-1:0]   mdu_result;
    logic [XLEN-1:0]   mdu_pc;
    logic [ID_W-1:0]   mdu_id;
    logic [PREG_W-1:0] mdu_prd;

    // Route the issue strobe by the top opcode bit
    assign alu_valid = issue_valid_i && !is_mdu_op(op_i);
    assign mdu_start = issue_valid_i && is_mdu_op(op_i);

    fu_alu u_alu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .op_i     (op_i),
        .size_i   (size_i),
        .rs1val_i (rs1val_i),
        .rs2val_i (rs2val_i),
        .imm_i    (imm_i),
        .result_o (alu_result)
    );

    mdu_ctrl u_mdu_ctrl (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (mdu_start),
        .last_i    (cnt_last),
        .parked_i  (parked),
        .load_o    (mdu_load),
        .step_o    (mdu_step),
        .cnt_clr_o (cnt_clr),
        .cnt_en_o  (cnt_en),
        .done_o    (mdu_done),
        .busy_o    (busy_o)
    );

    mdu_cycle_counter u_mdu_cnt (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (cnt_clr),
        .en_i    (cnt_en),
        .last_o  (cnt_last)
    );

    mdu_datapath u_mdu_dp (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .load_i   (mdu_load),
        .step_i   (mdu_step),
        .op_i     (op_i),
        .rs1val_i (rs1val_i),
        .rs2val_i (rs2val_i),
        .pc_i     (pc_i),
        .id_i     (id_i),
        .prd_i    (prd_i),
        .result_o (mdu_result),
        .pc_o     (mdu_pc),
        .id_o     (mdu_id),
        .prd_o    (mdu_prd)
    );

    exec_writeback u_wb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .alu_valid_i  (alu_valid),
        .alu_result_i (alu_result),
        .alu_pc_i     (pc_i),
        .alu_id_i     (id_i),
        .alu_prd_i    (prd_i),
        .mdu_done_i   (mdu_done),
        .mdu_result_i (mdu_result),
        .mdu_pc_i     (mdu_pc),
        .mdu_id_i     (mdu_id),
        .mdu_prd_i    (mdu_prd),
        .parked_o     (parked),
        .wb_valid_o   (wb_valid_o),
        .wb_id_o      (wb_id_o),
        .wb_prd_o     (wb_prd_o),
        .wb_pc_o      (wb_pc_o),
        .wb_rdval_o   (wb_rdval_o)
    );

endmodule

`default_nettype wire

//--- tb_exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_checker (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        issue_valid_i,
    input  logic [exec_pkg::ID_W-1:0]   issue_id_i,
    input  logic [exec_pkg::PREG_W-1:0] issue_prd_i,
    input  logic [exec_pkg::XLEN-1:0]   issue_pc_i,
    input  logic [exec_pkg::XLEN-1:0]   exp_value_i,
    input  logic                        exp_mdu_i,
    input  logic                        report_lost_i,
    input  logic                        busy_i,
    input  logic                        wb_valid_i,
    input  logic [exec_pkg::ID_W-1:0]   wb_id_i,
    input  logic [exec_pkg::PREG_W-1:0] wb_prd_i,
    input  logic [exec_pkg::XLEN-1:0]   wb_pc_i,
    input  logic [exec_pkg::XLEN-1:0]   wb_rdval_i,
    output int                          err_count_o,
    output int                          check_count_o,
    output int                          outstanding_o
);
    import exec_pkg::*;

    localparam int N_IDS = 2**ID_W;

    logic              pending   [N_IDS];  // Issued, not yet written back
    logic              is_mdu    [N_IDS];
    logic [XLEN-1:0]   exp_value [N_IDS];
    logic [XLEN-1:0]   exp_pc    [N_IDS];
    logic [PREG_W-1:0] exp_prd   [N_IDS];
    int                issued_at [N_IDS];
    int                cycle;
    logic              mdu_open;           // A multiply/divide op is in flight
    logic [ID_W-1:0]   mdu_id;

    initial begin
        for (int i = 0; i < N_IDS; i++) begin
            pending[i] = 1'b0;
        end
        err_count_o   = 0;
        check_count_o = 0;
        outstanding_o = 0;
        cycle         = 0;
        mdu_open      = 1'b0;
        mdu_id        = '0;
    end

    task automatic compare(input string name, input logic [ID_W-1:0] id,
                           input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
        if (got !== want) begin
            err_count_o++;
            $display("mismatch at %0t: %s for id %0d is %h, expected %h",
                     $time, name, id, got, want);
        end
    endtask

    task automatic check_result();
        if (!pending[wb_id_i]) begin
            err_count_o++;
            $display("Writeback at %0t carries id %0d, which has no open operation",
                     $time, wb_id_i);
        end else begin
            compare("wb_rdval_o", wb_id_i, wb_rdval_i, exp_value[wb_id_i]);
            compare("wb_pc_o", wb_id_i, wb_pc_i, exp_pc[wb_id_i]);
            compare("wb_prd_o", wb_id_i, XLEN'(wb_prd_i), XLEN'(exp_prd[wb_id_i]));
            if (is_mdu[wb_id_i]) begin
                if (busy_i) begin
                    err_count_o++;
                    $display("busy_o still high at %0t when id %0d was written back",
                             $time, wb_id_i);
                end
                mdu_open = 1'b0;
            end else if (cycle != issued_at[wb_id_i] + 1) begin
                err_count_o++;
                $display("ALU id %0d written back %0d cycles after issue instead of one",
                         wb_id_i, cycle - issued_at[wb_id_i]);
            end
            pending[wb_id_i] = 1'b0;
            outstanding_o--;
            check_count_o++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n_i) begin
            cycle = cycle + 1;
            // Busy covers the whole run up to the writeback
            if (mdu_open && !busy_i && !(wb_valid_i && wb_id_i == mdu_id)) begin
                err_count_o++;
                $display("busy_o low at %0t while id %0d is still running", $time, mdu_id);
                mdu_open = 1'b0;
            end
            if (wb_valid_i) begin
                check_result();
            end
            if (issue_valid_i) begin
                pending[issue_id_i]   = 1'b1;
                is_mdu[issue_id_i]    = exp_mdu_i;
                exp_value[issue_id_i] = exp_value_i;
                exp_pc[issue_id_i]    = issue_pc_i;
                exp_prd[issue_id_i]   = issue_prd_i;
                issued_at[issue_id_i] = cycle;
                outstanding_o++;
                if (exp_mdu_i) begin
                    mdu_open = 1'b1;
                    mdu_id   = issue_id_i;
                end
            end
            if (report_lost_i) begin
                for (int i = 0; i < N_IDS; i++) begin
                    if (pending[i]) begin
                        err_count_o++;
                        $display("Id %0d was issued but never written back", i);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;
    import exec_pkg::*;

    localparam int              TAB_MAX = 48;
    localparam logic [XLEN-1:0] PAT_A   = 64'hf0f0_1234_5678_9abc;
    localparam logic [XLEN-1:0] PAT_B   = 64'h0ff0_ffff_0000_ffff;
    localparam logic [XLEN-1:0] ONES    = '1;

    logic              clk;
    logic              rst_n_i;
    logic              issue_valid_i;
    fu_op_u            op_i;
    size_e             size_i;
    logic [XLEN-1:0]   rs1val_i;
    logic [XLEN-1:0]   rs2val_i;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   pc_i;
    logic [ID_W-1:0]   id_i;
    logic [PREG_W-1:0] prd_i;
    logic              busy_o;
    logic              wb_valid_o;
    logic [ID_W-1:0]   wb_id_o;
    logic [PREG_W-1:0] wb_prd_o;
    logic [XLEN-1:0]   wb_pc_o;
    logic [XLEN-1:0]   wb_rdval_o;

    logic              exp_mdu;
    logic [XLEN-1:0]   exp_value;
    logic              report_lost;
    int                err_count;
    int                check_count;
    int                outstanding;

    // Stimulus table with one row per operation
    fu_op_u            tab_op   [TAB_MAX];
    size_e             tab_size [TAB_MAX];
    logic [XLEN-1:0]   tab_rs1  [TAB_MAX];
    logic [XLEN-1:0]   tab_rs2  [TAB_MAX];
    logic [XLEN-1:0]   tab_imm  [TAB_MAX];
    logic [XLEN-1:0]   tab_res  [TAB_MAX];
    logic              tab_mdu  [TAB_MAX];
    int                tab_gap  [TAB_MAX];  // Idle cycles before the row
    int                n_rows;
    logic              table_ready;
    integer            seed;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    exec_cluster uut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .op_i          (op_i),
        .size_i        (size_i),
        .rs1val_i      (rs1val_i),
        .rs2val_i      (rs2val_i),
        .imm_i         (imm_i),
        .pc_i          (pc_i),
        .id_i          (id_i),
        .prd_i         (prd_i),
        .busy_o        (busy_o),
        .wb_valid_o    (wb_valid_o),
        .wb_id_o       (wb_id_o),
        .wb_prd_o      (wb_prd_o),
        .wb_pc_o       (wb_pc_o),
        .wb_rdval_o    (wb_rdval_o)
    );

    tb_exec_checker u_check (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_id_i    (id_i),
        .issue_prd_i   (prd_i),
        .issue_pc_i    (pc_i),
        .exp_value_i   (exp_value),
        .exp_mdu_i     (exp_mdu),
        .report_lost_i (report_lost),
        .busy_i        (busy_o),
        .wb_valid_i    (wb_valid_o),
        .wb_id_i       (wb_id_o),
        .wb_prd_i      (wb_prd_o),
        .wb_pc_i       (wb_pc_o),
        .wb_rdval_i    (wb_rdval_o),
        .err_count_o   (err_count),
        .check_count_o (check_count),
        .outstanding_o (outstanding)
    );

    // Unsigned multiply/divide results with ISA division by zero
    function automatic logic [XLEN-1:0] mdu_model(input logic [4:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        if (op == MUL) begin
            return prod[XLEN-1:0];
        end else if (op == MULHU) begin
            return prod[2*XLEN-1:XLEN];
        end else if (op == DIVU) begin
            return (b == '0) ? ONES : a / b;
        end
        return (b == '0) ? a : a % b;  // REMU
    endfunction

    task automatic add_row(input logic [4:0] op, input size_e size, input logic [XLEN-1:0] rs1,
                           input logic [XLEN-1:0] rs2, input logic [XLEN-1:0] imm,
                           input logic [XLEN-1:0] result, input int gap = 0);
        tab_op[n_rows]   = op;
        tab_size[n_rows] = size;
        tab_rs1[n_rows]  = rs1;
        tab_rs2[n_rows]  = rs2;
        tab_imm[n_rows]  = imm;
        tab_res[n_rows]  = result;
        tab_mdu[n_rows]  = op[4];  // Multiply/divide codes carry the top bit
        tab_gap[n_rows]  = gap;
        n_rows++;
    endtask

    task automatic add_random_mdu_row(input logic [4:0] op);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        if (op inside {DIVU, REMU}) begin
            b = b >> b[5:0];  // Smaller divisors give wider quotients
        end
        add_row(op, SIZE_D, a, b, '0, mdu_model(op, a, b));
    endtask

    task automatic build_table();
        add_row(ADD,   SIZE_D, 64'hffff_ffff_ffff_fff0, 64'h20, '0, 64'h10);
        add_row(SUB,   SIZE_D, 64'h5, 64'h7, '0, 64'hffff_ffff_ffff_fffe);
        add_row(AND,   SIZE_D, PAT_A, PAT_B, '0, 64'h00f0_1234_0000_9abc);
        add_row(OR,    SIZE_D, PAT_A, PAT_B, '0, 64'hfff0_ffff_5678_ffff);
        add_row(XOR,   SIZE_D, PAT_A, PAT_B, '0, 64'hff00_edcb_5678_6543);
        add_row(LUI,   SIZE_D, 64'h1234, '0, 64'hffff_ffff_8765_4000, 64'hffff_ffff_8765_4000);
        add_row(AUIPC, SIZE_D, 64'h8000_1000, '0, 64'h1_2000, 64'h8001_3000);  // Pc in rs1
        // Word forms
        add_row(ADD, SIZE_W, 64'h7fff_ffff, 64'h1, '0, 64'hffff_ffff_8000_0000);
        add_row(SUB, SIZE_W, 64'h1234_5678_0000_0000, 64'h1, '0, ONES);
        add_row(SLL, SIZE_W, 64'h1, 64'd31, 64'd31, 64'hffff_ffff_8000_0000);
        add_row(SRL, SIZE_W, 64'hffff_ffff_8000_0000, 64'd36, 64'd36, 64'h0800_0000);
        add_row(SRA, SIZE_W, 64'h8000_0000, 64'd4, 64'd4, 64'hffff_ffff_f800_0000);
        // Shift amount travels in imm as well as rs2
        add_row(SLL, SIZE_D, 64'h3, 64'd63, 64'd63, 64'h8000_0000_0000_0000);
        add_row(SLL, SIZE_D, 64'h0123_4567_89ab_cdef, 64'd4, 64'd4, 64'h1234_5678_9abc_def0);
        add_row(SRL, SIZE_D, 64'h8000_0000_0000_0000, 64'd63, 64'd63, 64'h1);
        add_row(SRL, SIZE_D, 64'hdead_beef_0123_4567, '0, '0, 64'hdead_beef_0123_4567);
        add_row(SRA, SIZE_D, 64'h8000_0000_0000_0000, 64'd63, 64'd63, ONES);
        add_row(SRA, SIZE_D, 64'hf000_0000_0000_1230, 64'd4, 64'd4, 64'hff00_0000_0000_0123);
        add_row(SLT,  SIZE_D, ONES, 64'h1, '0, 64'h1);
        add_row(SLTU, SIZE_D, ONES, 64'h1, '0, 64'h0);
        add_row(SLT,  SIZE_D, 64'h1, ONES, '0, 64'h0);
        add_row(SLTU, SIZE_D, 64'h1, ONES, '0, 64'h1);
        add_row(SLT,  SIZE_D, 64'hffff_ffff_ffff_fffb, 64'hffff_ffff_ffff_fffd, '0, 64'h1);
        add_row(DIVU, SIZE_D, 64'd100, '0, '0, ONES);
        add_row(REMU, SIZE_D, 64'h1234_5678_9abc_def0, '0, '0, 64'h1234_5678_9abc_def0);
        repeat (2) begin
            add_random_mdu_row(MUL);
            add_random_mdu_row(MULHU);
            add_random_mdu_row(DIVU);
            add_random_mdu_row(REMU);
        end
        // ALU op lands in the done cycle and a second one keeps the result parked
        add_random_mdu_row(MUL);
        add_row(ADD, SIZE_D, 64'h1, 64'h2, '0, 64'h3, MDU_STEPS);
        add_row(XOR, SIZE_D, PAT_A, PAT_A, '0, '0);
        add_random_mdu_row(DIVU);
        add_row(OR,  SIZE_D, PAT_A, '0, '0, PAT_A, MDU_STEPS);
        add_row(SUB, SIZE_D, 64'h10, 64'h10, '0, '0);
    endtask

    task automatic issue_row(input int i);
        issue_valid_i <= 1'b1;
        op_i          <= tab_op[i];
        size_i        <= tab_size[i];
        rs1val_i      <= tab_rs1[i];
        rs2val_i      <= tab_rs2[i];
        imm_i         <= tab_imm[i];
        pc_i          <= 64'h8000_0000 + XLEN'(4 * i);
        id_i          <= ID_W'(i);
        prd_i         <= PREG_W'(i + 40);
        exp_value     <= tab_res[i];
        exp_mdu       <= tab_mdu[i];
    endtask

    initial begin
        int drain;
        seed          = 32'h901f_37a5;
        table_ready   = 1'b0;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        op_i          = '0;
        size_i        = SIZE_D;
        rs1val_i      = '0;
        rs2val_i      = '0;
        imm_i         = '0;
        pc_i          = '0;
        id_i          = '0;
        prd_i         = '0;
        exp_value     = '0;
        exp_mdu       = 1'b0;
        report_lost   = 1'b0;
        n_rows        = 0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            repeat (tab_gap[i]) begin
                @(posedge clk);
                issue_valid_i <= 1'b0;
            end
            if (tab_mdu[i]) begin
                @(posedge clk);
                issue_valid_i <= 1'b0;
                @(negedge clk);
                while (busy_o) @(negedge clk);  // Issuer respects busy
            end
            @(posedge clk);
            issue_row(i);
        end
        @(posedge clk);
        issue_valid_i <= 1'b0;
        drain = 0;
        @(negedge clk);
        while (outstanding != 0 && drain < MDU_STEPS + 8) begin
            @(negedge clk);
            drain++;
        end
        @(posedge clk);
        report_lost <= 1'b1;
        @(posedge clk);
        report_lost <= 1'b0;
        @(negedge clk);
        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        wait (table_ready);
        limit = n_rows * (MDU_STEPS + 4) + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results outstanding", limit, outstanding);
        $display("Checks %0d, errors %0d", check_count, err_count + 1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
exec_pkg.sv
fu_alu.sv
mdu_ctrl.sv
mdu_cycle_counter.sv
mdu_datapath.sv
exec_writeback.sv
exec_cluster.sv
tb_exec_checker.sv
tb_exec_cluster.sv
